//--- tb/trigger_patterns.txt
# name mode stream acq soft rise flen delay kind width count spacing, then expected:
# low_pulses low_len accepted delay_drops extend_drops (kind: hw pulse, sw handshake, burst)
gate_mode        0 1 1 0 1 4 0   hw    12 1 0    0 0  0 0 0
gate_stream      1 0 1 0 1 4 0   hw    12 1 0    0 0  0 0 0
gate_acq         1 1 0 0 1 4 0   hw    12 1 0    0 0  0 0 0
filt_short       1 1 1 0 1 8 0   hw    5  1 0    0 0  0 0 0
filt_long        1 1 1 0 1 8 0   hw    14 1 0    1 64 1 0 0
filt_zero        1 1 1 0 1 0 3   hw    5  1 0    1 64 1 0 0
edge_fall        1 1 1 0 0 6 10  hw    20 1 0    1 64 1 0 0
edge_fall_short  1 1 1 0 0 6 0   hw    4  1 0    0 0  0 0 0
soft_one         1 1 1 1 1 4 5   sw    0  1 0    1 64 1 0 0
soft_no_line     1 1 1 1 1 4 0   hw    20 1 0    0 0  0 0 0
soft_gated       1 1 0 1 1 4 0   sw    0  1 0    0 0  0 0 0
delay_drop       1 1 1 1 1 4 200 burst 0  2 20   1 64 1 1 0
extend_drop      1 1 1 1 1 4 0   burst 0  2 20   1 64 1 0 1
hw_overlap       1 1 1 0 1 2 0   burst 8  2 30   1 64 1 0 1
spaced_pair      1 1 1 1 1 4 10  burst 0  2 100  2 64 2 0 0
back_to_hw       1 1 1 0 1 3 2   hw    10 1 0    1 64 1 0 0

//--- trigger_path.f
logic/trigger_pkg.sv
logic/trigger_input.sv
logic/trigger_delay.sv
logic/trigger_extend.sv
logic/trigger_path.sv
tb/trigger_path_properties.sv
tb/trigger_path_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
	--top-module trigger_path_tb \
	-f trigger_path.f \
	--Mdir "$OBJ" -o trigger_path_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/trigger_path_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	echo "simulation PASSED"
	exit 0
fi
echo "simulation FAILED"
exit 1

//--- tb/trigger_path_tb.sv
// runs from the project root and reads tb/trigger_patterns.txt; status counters accumulate over tests
module trigger_path_tb;
	import trigger_pkg::*;

	localparam int EXT_LEN = 64;
	localparam int TIMEOUT = 3000;

	logic            clk;
	logic            i_reset;
	trigger_cfg_t    i_cfg;
	logic            i_line;
	logic            i_soft_valid;
	logic            o_soft_ready;
	logic            o_trigger_n;
	trigger_status_t o_status;

	// cycle number of the last rising edge
	int          cycle;
	// low pulse monitor results
	int          pulses;
	int          low_len;
	int          last_len;
	int          low_start;
	// line edge times of the last hardware pulse
	int          edge_hi;
	int          edge_lo;
	int          errors;
	int          test_errors;
	logic [31:0] lfsr;

	trigger_path #(.EXTEND_LENGTH(EXT_LEN)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// sensor trigger sampled mid cycle
	always @(negedge clk) begin
		if (!o_trigger_n) begin
			if (low_len == 0) begin
				low_start <= cycle;
			end
			low_len <= low_len + 1;
		end else if (low_len != 0) begin
			pulses   <= pulses + 1;
			last_len <= low_len;
			low_len  <= 0;
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		repeat (n) begin
			lfsr  = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// n rising edges, then the drive point
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#10;
	endtask

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("tests failed");
		$finish;
	endtask

	task automatic check(input string test, input string what, input int expected,
		input int actual);
		if (expected != actual) begin
			$display("ERR %s %s: expected %0d, actual %0d", test, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic line_pulse(input int width);
		i_line  = 1'b1;
		edge_hi = cycle;
		step(width);
		i_line  = 1'b0;
		edge_lo = cycle;
	endtask

	// valid held until the edge that sees ready
	task automatic soft_trigger();
		int n;
		n = 0;
		i_soft_valid = 1'b1;
		while (!o_soft_ready) begin
			if (n == TIMEOUT) begin
				give_up("soft ready");
			end
			step(1);
			n++;
		end
		step(1);
		i_soft_valid = 1'b0;
	endtask

	// expected pulses seen and the output high for a whole window
	task automatic wait_done(input int base, input int want, input int window);
		int n;
		int calm;
		n    = 0;
		calm = 0;
		while (pulses - base < want || calm < window) begin
			if (n == TIMEOUT) begin
				give_up("the trigger output to settle");
			end
			@(negedge clk);
			calm = o_trigger_n ? calm + 1 : 0;
			n++;
		end
		step(1);
	endtask

	// ----------------------------------------------------------------------
	// pattern driven tests
	// ----------------------------------------------------------------------
	initial begin
		int    fd;
		int    n;
		string line;
		string name;
		string kind;
		int    f_mode;
		int    f_stream;
		int    f_acq;
		int    f_soft;
		int    f_rise;
		int    f_flen;
		int    f_delay;
		int    width;
		int    count;
		int    spacing;
		int    jitter;
		int    e_pulses;
		int    e_low;
		int    e_acc;
		int    e_ddrop;
		int    e_edrop;
		int    exp_acc;
		int    exp_ddrop;
		int    exp_edrop;
		int    base;
		int    fire;
		int    tests;
		int    failed;

		i_reset      = 1'b1;
		i_cfg        = '0;
		i_line       = 1'b0;
		i_soft_valid = 1'b0;
		lfsr         = 32'h622d;
		exp_acc      = 0;
		exp_ddrop    = 0;
		exp_edrop    = 0;
		tests        = 0;
		failed       = 0;
		step(10);
		i_reset = 1'b0;
		step(2);

		fd = $fopen("tb/trigger_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%s %d %d %d %d %d %d %d %s %d %d %d %d %d %d %d %d",
					name, f_mode, f_stream, f_acq, f_soft, f_rise, f_flen, f_delay,
					kind, width, count, spacing, e_pulses, e_low, e_acc, e_ddrop, e_edrop);
				if (n != 17) begin
					$display("pattern line could not be parsed: %s", line);
					errors++;
					continue;
				end
				test_errors = 0;
				i_cfg.trigger_mode      = f_mode[0];
				i_cfg.stream_enable     = f_stream[0];
				i_cfg.acquisition_start = f_acq[0];
				i_cfg.soft_source       = f_soft[0];
				i_cfg.rising_edge       = f_rise[0];
				i_cfg.filter_len        = filter_len_t'(f_flen);
				i_cfg.delay             = trig_delay_t'(f_delay);
				// enable register needs a cycle
				step(2);
				check(name, "soft ready", f_soft, int'(o_soft_ready));
				base = pulses;

				if (kind == "hw") begin
					line_pulse(width);
				end else if (kind == "sw") begin
					soft_trigger();
				end else begin
					// start to start spacing plus 0..7 cycles of jitter
					repeat (count) begin
						random_bits(3, jitter);
						if (f_soft[0]) begin
							soft_trigger();
							step(spacing + jitter - 1);
						end else begin
							line_pulse(width);
							step(spacing + jitter - width);
						end
					end
				end
				wait_done(base, e_pulses, (f_flen > 0 ? f_flen : 1) + f_delay + 10);

				exp_acc   += e_acc;
				exp_ddrop += e_ddrop;
				exp_edrop += e_edrop;
				check(name, "low pulses", e_pulses, pulses - base);
				if (e_pulses > 0) begin
					check(name, "low length", e_low, last_len);
				end
				check(name, "accepted", exp_acc, int'(o_status.accepted));
				check(name, "delay drops", exp_ddrop, int'(o_status.delay_drops));
				check(name, "extend drops", exp_edrop, int'(o_status.extend_drops));
				// sync 2, filter, edge 1, delay+1, output 1
				if (kind == "hw" && e_pulses == 1) begin
					fire = f_rise[0] ? edge_hi : edge_lo;
					check(name, "trigger latency", (f_flen > 0 ? f_flen : 1) + f_delay + 5,
						low_start - fire);
				end

				tests++;
				if (test_errors == 0) begin
					$display("PASS %s", name);
				end else begin
					$display("FAIL %s", name);
					failed++;
				end
			end
			$fclose(fd);
		end

		$display("summary: %0d run, %0d passed, %0d failed, %0d errors",
			tests, tests - failed, failed, errors);
		if (errors == 0 && tests > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- tb/trigger_path_properties.sv
// bound into trigger_path; EXTEND_LENGTH follows the bound instance, cfg assumed static per test
module trigger_path_properties #(
	parameter int EXTEND_LENGTH = 8192
) (
	input logic                      clk,
	input logic                      i_reset,
	input trigger_pkg::trigger_cfg_t i_cfg,
	input logic                      o_soft_ready,
	input logic                      o_trigger_n
);

	// low samples so far in the running pulse
	int low_run;

	always_ff @(posedge clk) begin
		if (i_reset || o_trigger_n) begin
			low_run <= 0;
		end else begin
			low_run <= low_run + 1;
		end
	end

	// ----------------------------------------------------------------------
	// handshake and output pulse
	// ----------------------------------------------------------------------

	// ready low for the hardware line and while held in reset
	a_ready_follows_source: assert property (@(posedge clk)
		!i_cfg.soft_source || ($past(i_reset) && i_reset) |-> !o_soft_ready)
		else $error("soft ready high with the hardware line selected or in reset");

	// whole pulse, exactly EXTEND_LENGTH samples low
	a_pulse_length: assert property (@(posedge clk) disable iff (i_reset)
		$rose(o_trigger_n) |-> low_run == EXTEND_LENGTH)
		else $error("sensor trigger low for %0d cycles", low_run);

	a_pulse_bound: assert property (@(posedge clk) disable iff (i_reset)
		!o_trigger_n |-> low_run < EXTEND_LENGTH)
		else $error("sensor trigger low too long");

	// first reset edge loads the flop
	a_idle_in_reset: assert property (@(posedge clk) $past(i_reset) && i_reset |-> o_trigger_n)
		else $error("sensor trigger active during reset");

endmodule

bind trigger_path trigger_path_properties #(
	.EXTEND_LENGTH (EXTEND_LENGTH)
) u_props (
	.clk          (clk),
	.i_reset      (i_reset),
	.i_cfg        (i_cfg),
	.o_soft_ready (o_soft_ready),
	.o_trigger_n  (o_trigger_n)
);

//--- logic/trigger_path.sv
// i_cfg comes from the register block and is held static during a test; no trigger queuing
module trigger_path #(
	parameter int EXTEND_LENGTH = 8192
) (
	input  logic                         clk,
	input  logic                         i_reset,
	input  trigger_pkg::trigger_cfg_t    i_cfg,
	input  logic                         i_line,
	input  logic                         i_soft_valid,
	output logic                         o_soft_ready,
	output logic                         o_trigger_n,
	output trigger_pkg::trigger_status_t o_status
);
	import trigger_pkg::*;

	// stage to stage pulses, no back-pressure
	logic         trig_pulse;
	logic         release_pulse;
	// status counters from each stage
	event_count_t delay_drops;
	event_count_t accept_count;
	event_count_t extend_drops;

	// ----------------------------------------------------------------------
	// source select, filter, handshake
	// ----------------------------------------------------------------------
	trigger_input i_input (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_cfg        (i_cfg),
		.i_line       (i_line),
		.i_soft_valid (i_soft_valid),
		.o_soft_ready (o_soft_ready),
		.o_trig_pulse (trig_pulse)
	);

	// programmable delay
	trigger_delay i_delay (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_delay         (i_cfg.delay),
		.i_trig_pulse    (trig_pulse),
		.o_release_pulse (release_pulse),
		.o_drop_count    (delay_drops)
	);

	// sensor pulse, active low
	trigger_extend #(
		.EXTEND_LENGTH (EXTEND_LENGTH)
	) i_extend (
		.clk                 (clk),
		.i_reset             (i_reset),
		.i_trigger_mode      (i_cfg.trigger_mode),
		.i_stream_enable     (i_cfg.stream_enable),
		.i_acquisition_start (i_cfg.acquisition_start),
		.i_release_pulse     (release_pulse),
		.o_trigger_n         (o_trigger_n),
		.o_accept_count      (accept_count),
		.o_drop_count        (extend_drops)
	);

	// ----------------------------------------------------------------------
	// status
	// ----------------------------------------------------------------------
	assign o_status.accepted     = accept_count;
	assign o_status.delay_drops  = delay_drops;
	assign o_status.extend_drops = extend_drops;

endmodule

//--- logic/trigger_extend.sv
// EXTEND_LENGTH must be at least 1; enable changes only gate new triggers, never a running pulse
module trigger_extend #(
	parameter int EXTEND_LENGTH = 8192
) (
	input  logic                      clk,
	input  logic                      i_reset,
	input  logic                      i_trigger_mode,
	input  logic                      i_stream_enable,
	input  logic                      i_acquisition_start,
	input  logic                      i_release_pulse,
	output logic                      o_trigger_n,
	output trigger_pkg::event_count_t o_accept_count,
	output trigger_pkg::event_count_t o_drop_count
);
	import trigger_pkg::*;

	// length counter sized from the pulse length
	localparam int CNT_W = (EXTEND_LENGTH > 1) ? $clog2(EXTEND_LENGTH) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(EXTEND_LENGTH - 1);

	extend_state_t    state;
	logic             enable;
	logic [CNT_W-1:0] extend_cnt;

	// ----------------------------------------------------------------------
	// acquisition enable, registered every cycle
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			enable <= 1'b0;
		end else begin
			enable <= i_trigger_mode & i_stream_enable & i_acquisition_start;
		end
	end

	// ----------------------------------------------------------------------
	// pulse stretcher
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state          <= EXT_IDLE;
			o_trigger_n    <= 1'b1;
			o_accept_count <= '0;
			o_drop_count   <= '0;
		end else begin
			case (state)
				EXT_IDLE: begin
					// disabled triggers vanish without a count
					if (i_release_pulse && enable) begin
						state          <= EXT_LOW;
						o_trigger_n    <= 1'b0;
						o_accept_count <= o_accept_count + event_count_t'(1);
					end
				end
				EXT_LOW: begin
					// overlap with the running pulse
					if (i_release_pulse && enable) begin
						o_drop_count <= o_drop_count + event_count_t'(1);
					end
					if (extend_cnt == LAST_CNT) begin
						state       <= EXT_IDLE;
						o_trigger_n <= 1'b1;
					end
				end
				default: begin
					state       <= EXT_IDLE;
					o_trigger_n <= 1'b1;
				end
			endcase
		end
	end

	// counts the low cycles, back to zero at the end
	always_ff @(posedge clk) begin
		if (state == EXT_IDLE || extend_cnt == LAST_CNT) begin
			extend_cnt <= '0;
		end else begin
			extend_cnt <= extend_cnt + CNT_W'(1);
		end
	end

endmodule

//--- logic/trigger_delay.sv
// i_delay is sampled when a pulse is accepted; pulses arriving while counting are dropped, not queued
module trigger_delay (
	input  logic                      clk,
	input  logic                      i_reset,
	input  trigger_pkg::trig_delay_t  i_delay,
	input  logic                      i_trig_pulse,
	output logic                      o_release_pulse,
	output trigger_pkg::event_count_t o_drop_count
);
	import trigger_pkg::*;

	delay_state_t state;
	// cycles left before release
	trig_delay_t  remain;
	logic         start_count;

	// accepted pulse with a nonzero delay
	assign start_count = (state == DLY_IDLE) && i_trig_pulse && (i_delay != '0);

	// ----------------------------------------------------------------------
	// control fsm
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state           <= DLY_IDLE;
			o_release_pulse <= 1'b0;
			o_drop_count    <= '0;
		end else begin
			o_release_pulse <= 1'b0;
			case (state)
				DLY_IDLE: begin
					if (i_trig_pulse) begin
						// zero delay goes straight out next cycle
						if (i_delay == '0) begin
							o_release_pulse <= 1'b1;
						end else begin
							state <= DLY_COUNT;
						end
					end
				end
				DLY_COUNT: begin
					// busy, lose it
					if (i_trig_pulse) begin
						o_drop_count <= o_drop_count + event_count_t'(1);
					end
					if (remain == '0) begin
						o_release_pulse <= 1'b1;
						state           <= DLY_IDLE;
					end
				end
				default: begin
					state <= DLY_IDLE;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// down counter
	// ----------------------------------------------------------------------

	// loaded with delay-1 so release lands delay+1 after the pulse
	always_ff @(posedge clk) begin
		if (start_count) begin
			remain <= i_delay - trig_delay_t'(1);
		end else if (state == DLY_COUNT && remain != '0) begin
			remain <= remain - trig_delay_t'(1);
		end
	end

endmodule

//--- logic/trigger_input.sv
// i_line is asynchronous and idles low after reset; soft_source picks exactly one trigger source
module trigger_input (
	input  logic                      clk,
	input  logic                      i_reset,
	input  trigger_pkg::trigger_cfg_t i_cfg,
	input  logic                      i_line,
	input  logic                      i_soft_valid,
	output logic                      o_soft_ready,
	output logic                      o_trig_pulse
);
	import trigger_pkg::*;

	// two flop synchronizer
	logic        sync_meta;
	logic        sync_line;
	// filtered level and its previous value
	logic        filt_level;
	logic        filt_level_d;
	// samples seen that differ from filt_level
	filter_len_t stable_cnt;
	filter_len_t filt_len_eff;
	// high once the stage has left reset
	logic        running;
	logic        soft_fire;
	logic        hw_edge;

	// ----------------------------------------------------------------------
	// line synchronizer
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			sync_meta <= 1'b0;
			sync_line <= 1'b0;
		end else begin
			sync_meta <= i_line;
			sync_line <= sync_meta;
		end
	end

	// ----------------------------------------------------------------------
	// glitch filter
	// ----------------------------------------------------------------------

	// zero length behaves as a single sample
	assign filt_len_eff = (i_cfg.filter_len == '0) ? filter_len_t'(1) : i_cfg.filter_len;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			stable_cnt   <= '0;
			filt_level   <= 1'b0;
			filt_level_d <= 1'b0;
		end else begin
			filt_level_d <= filt_level;
			if (sync_line == filt_level) begin
				// glitch or no change, start over
				stable_cnt <= '0;
			end else if (stable_cnt >= filt_len_eff - filter_len_t'(1)) begin
				// held long enough, take the new level
				filt_level <= sync_line;
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + filter_len_t'(1);
			end
		end
	end

	// configured edge on the filtered level
	assign hw_edge = (filt_level != filt_level_d) && (filt_level == i_cfg.rising_edge);

	// ----------------------------------------------------------------------
	// software handshake
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	// never stalls, a busy path downstream drops and counts
	assign o_soft_ready = i_cfg.soft_source & running;
	assign soft_fire    = i_soft_valid & o_soft_ready;

	// one cycle pulse, only the selected source can fire
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_trig_pulse <= 1'b0;
		end else begin
			o_trig_pulse <= i_cfg.soft_source ? soft_fire : hw_edge;
		end
	end

endmodule

//--- logic/trigger_pkg.sv
// shared trigger types; cfg fields are expected to stay static while a trigger is in flight
package trigger_pkg;

	// ----------------------------------------------------------------------
	// widths with a meaning
	// ----------------------------------------------------------------------

	// stable samples needed by the glitch filter, 0 acts as 1
	typedef logic [7:0]  filter_len_t;
	// trigger delay in clock cycles
	typedef logic [15:0] trig_delay_t;
	// status counter, wraps at full scale
	typedef logic [15:0] event_count_t;

	// ----------------------------------------------------------------------
	// register block view of the trigger path
	// ----------------------------------------------------------------------
	typedef struct packed {
		// 1 trigger mode, 0 free-run (nothing passes)
		logic        trigger_mode;
		logic        stream_enable;
		logic        acquisition_start;
		// 1 software handshake, 0 hardware line
		logic        soft_source;
		// 1 rising edge, 0 falling edge
		logic        rising_edge;
		filter_len_t filter_len;
		trig_delay_t delay;
	} trigger_cfg_t;

	// counters reported back to the register block
	typedef struct packed {
		event_count_t accepted;
		event_count_t delay_drops;
		event_count_t extend_drops;
	} trigger_status_t;

	// ----------------------------------------------------------------------
	// state machines
	// ----------------------------------------------------------------------
	typedef enum logic {
		DLY_IDLE,
		DLY_COUNT
	} delay_state_t;

	typedef enum logic {
		EXT_IDLE,
		EXT_LOW
	} extend_state_t;

endpackage
